// ==== include/ddr_consts.svh ====
// DDR memory subsystem constants
// Widths, controller model timing and APB register offsets
`ifndef DDR_CONSTS_SVH
`define DDR_CONSTS_SVH

// Data path and address widths
`define DDR_DATA_W            32
`define DDR_ADDR_W            6
`define DDR_TEMP_W            12
`define APB_ADDR_W            8

// Controller model timing, in clock cycles
`define DDR_PLL_LOCK_CYCLES   16
`define DDR_CALIB_CYCLES      32
`define DDR_REFRESH_INTERVAL  200
`define DDR_TRFC              8
`define DDR_TZQ               12

// APB register offsets
`define DDR_REG_STATUS        8'h00
`define DDR_REG_TEMP          8'h04
`define DDR_REG_CTRL          8'h08
`define DDR_REG_REFCNT        8'h0C
`define DDR_REG_ZQCNT         8'h10

`endif

// ==== hdl/apb_regs_pkg.sv ====
// APB register map of the DDR status and control block
// Register selector decoded from the bus address and the access rule
// that goes with it
package apb_regs_pkg;

  // One value per mapped register, REG_NONE for any other offset
  typedef enum logic [2:0] {
    REG_STATUS = 3'd0,
    REG_TEMP   = 3'd1,
    REG_CTRL   = 3'd2,
    REG_REFCNT = 3'd3,
    REG_ZQCNT  = 3'd4,
    REG_NONE   = 3'd5
  } reg_sel_t;

  // Status, temperature and counters are read only
  function automatic logic reg_writable(reg_sel_t sel);
    return (sel == REG_CTRL);
  endfunction

endpackage

// ==== hdl/ddr_ctrl_pkg.sv ====
// Behavior of the DDR controller model
// Maintenance states shared by the scheduler and the top level
package ddr_ctrl_pkg;

  // Only one maintenance activity runs at a time
  typedef enum logic [1:0] {
    MS_IDLE    = 2'd0,
    MS_REFRESH = 2'd1,
    MS_ZQ      = 2'd2,
    MS_SELFREF = 2'd3
  } maint_state_t;

  // Every state other than idle keeps the memory port closed
  function automatic logic state_blocks_port(maint_state_t st);
    return (st != MS_IDLE);
  endfunction

endpackage

// ==== hdl/apb_ddr.sv ====
// APB status and control registers of the DDR subsystem
// Reports lock, calibration, self-refresh and temperature, turns CTRL
// writes into refresh and ZQ request pulses and counts acknowledges
`timescale 1ns/100ps
`include "ddr_consts.svh"

module apb_ddr (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`APB_ADDR_W-1:0] i_paddr,
  input  logic [`DDR_DATA_W-1:0] i_pwdata,
  output logic [`DDR_DATA_W-1:0] o_prdata,
  output logic                   o_pready,
  output logic                   o_pslverr,
  input  logic                   i_pll_locked,
  input  logic                   i_init_calib_done,
  input  logic                   i_sr_active,
  input  logic                   i_ref_ack,
  input  logic                   i_zq_ack,
  input  logic [`DDR_TEMP_W-1:0] i_device_temp,
  output logic                   o_ref_req,
  output logic                   o_zq_req,
  output logic                   o_sr_en
);

  import apb_regs_pkg::*;

  localparam int CNT_W = 16;

  reg_sel_t         w_sel;
  logic             w_access;
  logic             w_wr_ctrl;
  logic [CNT_W-1:0] r_ref_cnt;
  logic [CNT_W-1:0] r_zq_cnt;

  always_comb begin
    case (i_paddr)
      `DDR_REG_STATUS: w_sel = REG_STATUS;
      `DDR_REG_TEMP:   w_sel = REG_TEMP;
      `DDR_REG_CTRL:   w_sel = REG_CTRL;
      `DDR_REG_REFCNT: w_sel = REG_REFCNT;
      `DDR_REG_ZQCNT:  w_sel = REG_ZQCNT;
      default:         w_sel = REG_NONE;
    endcase
  end

  // No wait states, every access phase completes at once
  assign w_access  = i_psel && i_penable;
  assign o_pready  = w_access;
  assign o_pslverr = w_access && ((w_sel == REG_NONE) || (i_pwrite && !reg_writable(w_sel)));
  assign w_wr_ctrl = w_access && i_pwrite && (w_sel == REG_CTRL);

  always_comb begin
    o_prdata = '0;
    case (w_sel)
      REG_STATUS: o_prdata[2:0] = {i_sr_active, i_init_calib_done, i_pll_locked};
      REG_TEMP:   o_prdata[`DDR_TEMP_W-1:0] = i_device_temp;
      REG_CTRL:   o_prdata[2] = o_sr_en;
      REG_REFCNT: o_prdata[CNT_W-1:0] = r_ref_cnt;
      REG_ZQCNT:  o_prdata[CNT_W-1:0] = r_zq_cnt;
      default:    o_prdata = '0;
    endcase
  end

  // CTRL bits 0 and 1 become one-cycle pulses, bit 2 is held
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_ref_req <= 1'b0;
      o_zq_req  <= 1'b0;
      o_sr_en   <= 1'b0;
    end else begin
      o_ref_req <= w_wr_ctrl && i_pwdata[0];
      o_zq_req  <= w_wr_ctrl && i_pwdata[1];
      if (w_wr_ctrl) begin
        o_sr_en <= i_pwdata[2];
      end
    end
  end

  // Acknowledge counters wrap at 16 bits
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_ref_cnt <= '0;
      r_zq_cnt  <= '0;
    end else begin
      if (i_ref_ack) begin
        r_ref_cnt <= r_ref_cnt + 1'b1;
      end
      if (i_zq_ack) begin
        r_zq_cnt <= r_zq_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== hdl/ddr_calib_seq.sv ====
// Clock lock and calibration model of the DDR controller
// One down-counter times the lock phase and then the calibration phase
// after reset; both flags stay set until the next reset
`timescale 1ns/100ps
`include "ddr_consts.svh"

module ddr_calib_seq (
  input  logic i_clk,
  input  logic i_rst,
  output logic o_pll_locked,
  output logic o_calib_done
);

  localparam int CNT_MAX = (`DDR_CALIB_CYCLES > `DDR_PLL_LOCK_CYCLES) ?
                           `DDR_CALIB_CYCLES : `DDR_PLL_LOCK_CYCLES;
  localparam int CNT_W   = $clog2(CNT_MAX);

  logic [CNT_W-1:0] r_cnt;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_cnt        <= CNT_W'(`DDR_PLL_LOCK_CYCLES - 1);
      o_pll_locked <= 1'b0;
      o_calib_done <= 1'b0;
    end else if (!o_calib_done) begin
      if (r_cnt != '0) begin
        r_cnt <= r_cnt - 1'b1;
      end else if (!o_pll_locked) begin
        // Lock reached, reload for calibration
        o_pll_locked <= 1'b1;
        r_cnt        <= CNT_W'(`DDR_CALIB_CYCLES - 1);
      end else begin
        o_calib_done <= 1'b1;
      end
    end
  end

endmodule

// ==== hdl/ddr_maint_sched.sv ====
// Maintenance scheduler of the DDR controller model
// Runs automatic and requested refresh, ZQ calibration and self-refresh,
// one at a time, in fixed priority: refresh, ZQ, self-refresh
`timescale 1ns/100ps
`include "ddr_consts.svh"

module ddr_maint_sched (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_calib_done,
  input  logic                       i_ref_req,
  input  logic                       i_zq_req,
  input  logic                       i_sr_en,
  input  logic                       i_port_idle,
  output logic                       o_ref_ack,
  output logic                       o_zq_ack,
  output logic                       o_sr_active,
  output logic                       o_maint_busy,
  output ddr_ctrl_pkg::maint_state_t o_state
);

  import ddr_ctrl_pkg::*;

  localparam int TIMER_W = $clog2(`DDR_REFRESH_INTERVAL);
  localparam int BUSY_W  = $clog2((`DDR_TZQ > `DDR_TRFC) ? `DDR_TZQ : `DDR_TRFC);

  maint_state_t       r_state;
  logic [TIMER_W-1:0] r_timer;
  logic [BUSY_W-1:0]  r_busy_cnt;
  logic               r_ref_pend;
  logic [1:0]         r_zq_pend;
  logic               w_timer_hit;
  logic               w_can_start;
  logic               w_grant_ref;
  logic               w_grant_zq;
  logic               w_grant_sr;

  assign w_timer_hit = i_calib_done && (r_timer == TIMER_W'(`DDR_REFRESH_INTERVAL - 1));
  assign w_can_start = i_calib_done && i_port_idle && (r_state == MS_IDLE);
  assign w_grant_ref = w_can_start && r_ref_pend;
  assign w_grant_zq  = w_can_start && !r_ref_pend && (r_zq_pend != 2'd0);
  assign w_grant_sr  = w_can_start && !r_ref_pend && (r_zq_pend == 2'd0) && i_sr_en;

  // Port closes in the grant cycle already
  assign o_maint_busy = state_blocks_port(r_state) || w_grant_ref || w_grant_zq || w_grant_sr;
  assign o_sr_active  = (r_state == MS_SELFREF);
  assign o_state      = r_state;

  // Interval timer and pending requests
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_timer    <= '0;
      r_ref_pend <= 1'b0;
      r_zq_pend  <= 2'd0;
    end else begin
      if (i_calib_done) begin
        r_timer <= w_timer_hit ? '0 : r_timer + 1'b1;
      end
      r_ref_pend <= (r_ref_pend && !w_grant_ref) || i_ref_req || w_timer_hit;
      // ZQ requests are counted so back-to-back writes each get a cycle
      case ({i_zq_req, w_grant_zq})
        2'b10:   r_zq_pend <= (r_zq_pend == 2'd3) ? r_zq_pend : r_zq_pend + 1'b1;
        2'b01:   r_zq_pend <= r_zq_pend - 1'b1;
        default: r_zq_pend <= r_zq_pend;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_state    <= MS_IDLE;
      r_busy_cnt <= '0;
      o_ref_ack  <= 1'b0;
      o_zq_ack   <= 1'b0;
    end else begin
      o_ref_ack <= 1'b0;
      o_zq_ack  <= 1'b0;
      case (r_state)
        MS_IDLE: begin
          if (w_grant_ref) begin
            r_state    <= MS_REFRESH;
            r_busy_cnt <= BUSY_W'(`DDR_TRFC - 1);
          end else if (w_grant_zq) begin
            r_state    <= MS_ZQ;
            r_busy_cnt <= BUSY_W'(`DDR_TZQ - 1);
          end else if (w_grant_sr) begin
            r_state <= MS_SELFREF;
          end
        end
        MS_REFRESH: begin
          if (r_busy_cnt == '0) begin
            r_state   <= MS_IDLE;
            o_ref_ack <= 1'b1;
          end else begin
            r_busy_cnt <= r_busy_cnt - 1'b1;
          end
        end
        MS_ZQ: begin
          if (r_busy_cnt == '0) begin
            r_state  <= MS_IDLE;
            o_zq_ack <= 1'b1;
          end else begin
            r_busy_cnt <= r_busy_cnt - 1'b1;
          end
        end
        MS_SELFREF: begin
          if (!i_sr_en) begin
            r_state <= MS_IDLE;
          end
        end
        default: r_state <= MS_IDLE;
      endcase
    end
  end

endmodule

// ==== hdl/ddr_mem_port.sv ====
// Word-wide memory port of the DDR controller model
// 64-word storage behind a valid/ready request port, closed until
// calibration ends and while maintenance runs; reads answer one cycle
// after acceptance
`timescale 1ns/100ps
`include "ddr_consts.svh"

module ddr_mem_port (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_calib_done,
  input  logic                   i_maint_busy,
  input  logic                   i_req_valid,
  input  logic                   i_req_we,
  input  logic [`DDR_ADDR_W-1:0] i_req_addr,
  input  logic [`DDR_DATA_W-1:0] i_req_wdata,
  output logic                   o_req_ready,
  output logic                   o_rsp_valid,
  output logic [`DDR_DATA_W-1:0] o_rsp_rdata,
  output logic                   o_port_idle
);

  localparam int DEPTH = 1 << `DDR_ADDR_W;

  logic [`DDR_DATA_W-1:0] r_mem [0:DEPTH-1];
  logic                   w_accept;

  assign o_req_ready = i_calib_done && !i_maint_busy;
  assign w_accept    = i_req_valid && o_req_ready;

  // Storage and read data
  always_ff @(posedge i_clk) begin
    if (w_accept && i_req_we) begin
      r_mem[i_req_addr] <= i_req_wdata;
    end
    if (w_accept && !i_req_we) begin
      o_rsp_rdata <= r_mem[i_req_addr];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rsp_valid <= 1'b0;
      o_port_idle <= 1'b1;
    end else begin
      o_rsp_valid <= w_accept && !i_req_we;
      // Idle when nothing was taken in the last cycle
      o_port_idle <= !w_accept;
    end
  end

endmodule

// ==== hdl/ddr_subsys.sv ====
// DDR memory subsystem top level
// APB register block beside a behavioral controller model made of the
// calibration sequencer, maintenance scheduler and memory port
`timescale 1ns/100ps
`include "ddr_consts.svh"

module ddr_subsys (
  input  logic                   i_clk,
  input  logic                   i_rst,
  // APB control
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`APB_ADDR_W-1:0] i_paddr,
  input  logic [`DDR_DATA_W-1:0] i_pwdata,
  output logic [`DDR_DATA_W-1:0] o_prdata,
  output logic                   o_pready,
  output logic                   o_pslverr,
  // Memory request port
  input  logic                   i_req_valid,
  input  logic                   i_req_we,
  input  logic [`DDR_ADDR_W-1:0] i_req_addr,
  input  logic [`DDR_DATA_W-1:0] i_req_wdata,
  output logic                   o_req_ready,
  output logic                   o_rsp_valid,
  output logic [`DDR_DATA_W-1:0] o_rsp_rdata,
  input  logic [`DDR_TEMP_W-1:0] i_device_temp,
  output logic                   o_init_calib_done
);

  import ddr_ctrl_pkg::*;

  logic         w_ref_req;
  logic         w_zq_req;
  logic         w_sr_en;
  logic         w_ref_ack;
  logic         w_zq_ack;
  logic         w_sr_active;
  logic         w_pll_locked;
  logic         w_calib_done;
  logic         w_maint_busy;
  logic         w_port_idle;
  // Scheduler state, observed by the checker
  maint_state_t w_maint_state;

  assign o_init_calib_done = w_calib_done;

  apb_ddr apb0 (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_psel(i_psel),
    .i_penable(i_penable),
    .i_pwrite(i_pwrite),
    .i_paddr(i_paddr),
    .i_pwdata(i_pwdata),
    .o_prdata(o_prdata),
    .o_pready(o_pready),
    .o_pslverr(o_pslverr),
    .i_pll_locked(w_pll_locked),
    .i_init_calib_done(w_calib_done),
    .i_sr_active(w_sr_active),
    .i_ref_ack(w_ref_ack),
    .i_zq_ack(w_zq_ack),
    .i_device_temp(i_device_temp),
    .o_ref_req(w_ref_req),
    .o_zq_req(w_zq_req),
    .o_sr_en(w_sr_en)
  );

  ddr_calib_seq calib0 (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .o_pll_locked(w_pll_locked),
    .o_calib_done(w_calib_done)
  );

  ddr_maint_sched maint0 (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_calib_done(w_calib_done),
    .i_ref_req(w_ref_req),
    .i_zq_req(w_zq_req),
    .i_sr_en(w_sr_en),
    .i_port_idle(w_port_idle),
    .o_ref_ack(w_ref_ack),
    .o_zq_ack(w_zq_ack),
    .o_sr_active(w_sr_active),
    .o_maint_busy(w_maint_busy),
    .o_state(w_maint_state)
  );

  ddr_mem_port port0 (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_calib_done(w_calib_done),
    .i_maint_busy(w_maint_busy),
    .i_req_valid(i_req_valid),
    .i_req_we(i_req_we),
    .i_req_addr(i_req_addr),
    .i_req_wdata(i_req_wdata),
    .o_req_ready(o_req_ready),
    .o_rsp_valid(o_rsp_valid),
    .o_rsp_rdata(o_rsp_rdata),
    .o_port_idle(w_port_idle)
  );

endmodule

// ==== tests/ddr_subsys_chk.sv ====
// Protocol checker for the DDR memory subsystem
// Watches the memory port handshake, the maintenance acknowledges
// and the scheduler state from inside the top level
`timescale 1ns/100ps
`include "ddr_consts.svh"

module ddr_subsys_chk (
  input logic                       i_clk,
  input logic                       i_rst,
  input logic                       i_calib_done,
  input logic                       i_req_valid,
  input logic                       i_req_we,
  input logic                       i_req_ready,
  input logic                       i_rsp_valid,
  input logic                       i_ref_ack,
  input logic                       i_zq_ack,
  input ddr_ctrl_pkg::maint_state_t i_state
);

  import ddr_ctrl_pkg::*;

  // Port opens only once calibration is done
  ready_after_calib: assert property (@(posedge i_clk) disable iff (i_rst)
    i_req_ready |-> i_calib_done)
    else $error("memory port ready before calibration done");

  // One response for every read taken in the cycle before
  rsp_follows_read: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rsp_valid == $past(i_req_valid && i_req_ready && !i_req_we))
    else $error("read response not one cycle after acceptance");

  acks_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_ref_ack && i_zq_ack))
    else $error("refresh and ZQ acknowledge high together");

  // A refresh lasts tRFC cycles and ends with its acknowledge
  refresh_window: assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(i_state == MS_REFRESH) |->
      ##(`DDR_TRFC) (i_ref_ack && (i_state == MS_IDLE)))
    else $error("refresh acknowledge not at the end of its window");

  // A ZQ cycle lasts tZQ cycles and ends with its acknowledge
  zq_window: assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(i_state == MS_ZQ) |->
      ##(`DDR_TZQ) (i_zq_ack && (i_state == MS_IDLE)))
    else $error("ZQ acknowledge not at the end of its window");

endmodule

bind ddr_subsys ddr_subsys_chk chk_i (
  .i_clk(i_clk),
  .i_rst(i_rst),
  .i_calib_done(o_init_calib_done),
  .i_req_valid(i_req_valid),
  .i_req_we(i_req_we),
  .i_req_ready(o_req_ready),
  .i_rsp_valid(o_rsp_valid),
  .i_ref_ack(w_ref_ack),
  .i_zq_ack(w_zq_ack),
  .i_state(w_maint_state)
);

// ==== tests/ddr_subsys_tb.sv ====
// Testbench for the DDR memory subsystem
// Applies a table of APB and memory port operations after reset and
// compares results with the register map and a shadow of the memory
`timescale 1ns/100ps
`include "ddr_consts.svh"

module ddr_subsys_tb;

  import apb_regs_pkg::*;

  localparam int N_TESTS = 29;
  localparam int LIMIT   = `DDR_PLL_LOCK_CYCLES + `DDR_CALIB_CYCLES + 40 * N_TESTS + 200;
  localparam logic [`DDR_TEMP_W-1:0] TEMP_VAL = 12'h5A3;

  typedef enum {K_CALIB, K_APB_WR, K_APB_RD, K_APB_POLL, K_APB_SNAP, K_APB_GT,
                K_MEM_WR, K_MEM_RD, K_NOT_READY} kind_t;

  typedef struct {
    string       name;
    kind_t       kind;
    reg_sel_t    sel;
    int          addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic        exp_err;
  } test_t;

  logic clk = 1'b0;
  logic rst;
  logic psel, penable, pwrite;
  logic [`APB_ADDR_W-1:0] paddr;
  logic [`DDR_DATA_W-1:0] pwdata, prdata;
  logic pready, pslverr;
  logic req_valid, req_we, req_ready, rsp_valid, calib_done;
  logic [`DDR_ADDR_W-1:0] req_addr;
  logic [`DDR_DATA_W-1:0] req_wdata, rsp_rdata;
  logic [`DDR_TEMP_W-1:0] device_temp;

  test_t       tbl [N_TESTS];
  logic [31:0] shadow [0:(1 << `DDR_ADDR_W)-1];
  logic [31:0] snap;
  int          n_added = 0;
  int          test_errs, pass_cnt, fail_cnt;
  int          cycles = 0;
  integer      seed = 73;

  ddr_subsys dut_i (
    .i_clk(clk), .i_rst(rst),
    .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite), .i_paddr(paddr),
    .i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
    .i_req_valid(req_valid), .i_req_we(req_we), .i_req_addr(req_addr),
    .i_req_wdata(req_wdata), .o_req_ready(req_ready), .o_rsp_valid(rsp_valid),
    .o_rsp_rdata(rsp_rdata), .i_device_temp(device_temp), .o_init_calib_done(calib_done)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: tests did not finish");
      $display("test failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic add_test(input string name, input kind_t kind, input reg_sel_t sel,
                          input int addr, input logic [31:0] data, input logic [31:0] exp,
                          input logic exp_err);
    tbl[n_added] = '{name, kind, sel, addr, data, exp, exp_err};
    n_added++;
  endtask

  // Offsets of the register map, an unused offset for REG_NONE
  function automatic logic [7:0] reg_addr(input reg_sel_t sel);
    case (sel)
      REG_STATUS: return `DDR_REG_STATUS;
      REG_TEMP:   return `DDR_REG_TEMP;
      REG_CTRL:   return `DDR_REG_CTRL;
      REG_REFCNT: return `DDR_REG_REFCNT;
      REG_ZQCNT:  return `DDR_REG_ZQCNT;
      default:    return 8'h14;
    endcase
  endfunction

  // Setup phase, access phase, then one idle cycle
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    if (!pready) begin
      $display("APB access to 0x%02h saw no pready in its access phase", addr);
      test_errs++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic mem_write(input int addr, input logic [31:0] data);
    @(posedge clk);
    req_valid <= 1'b1;
    req_we    <= 1'b1;
    req_addr  <= `DDR_ADDR_W'(addr);
    req_wdata <= data;
    do @(negedge clk); while (!req_ready);
    @(posedge clk);
    req_valid <= 1'b0;
    req_we    <= 1'b0;
    shadow[addr] = data;
  endtask

  // Reads back to back; each response must follow its acceptance by one cycle
  task automatic mem_read(input string name, input int base, input int count);
    int   issued;
    int   got;
    logic acc;
    logic acc_prev;
    int   pend_q[$];
    issued   = 0;
    got      = 0;
    acc_prev = 1'b0;
    @(posedge clk);
    req_valid <= 1'b1;
    req_we    <= 1'b0;
    req_addr  <= `DDR_ADDR_W'(base);
    while (got < count) begin
      @(negedge clk);
      check_value(name, acc_prev, rsp_valid);
      if (rsp_valid && pend_q.size() > 0) begin
        check_value(name, shadow[pend_q.pop_front()], rsp_rdata);
        got++;
      end
      acc = req_valid && req_ready;
      if (acc) begin
        pend_q.push_back(base + issued);
        issued++;
      end
      acc_prev = acc;
      @(posedge clk);
      if (acc && issued == count) begin
        req_valid <= 1'b0;
      end else if (acc) begin
        req_addr <= `DDR_ADDR_W'(base + issued);
      end
    end
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    int          n;
    rst <= 1'b1;
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= '0;
    pwdata <= '0;
    req_valid <= 1'b0;
    req_we <= 1'b0;
    req_addr <= '0;
    req_wdata <= '0;
    device_temp <= TEMP_VAL;
    pass_cnt = 0;
    fail_cnt = 0;

    add_test("calib", K_CALIB, REG_NONE, 0, 0, `DDR_PLL_LOCK_CYCLES + `DDR_CALIB_CYCLES, 0);
    add_test("status_init", K_APB_RD, REG_STATUS, 0, 0, 32'h3, 0);
    add_test("mem_wr_3", K_MEM_WR, REG_NONE, 3, 0, 0, 0);
    add_test("mem_wr_4", K_MEM_WR, REG_NONE, 4, 0, 0, 0);
    add_test("mem_wr_5", K_MEM_WR, REG_NONE, 5, 0, 0, 0);
    add_test("mem_wr_40", K_MEM_WR, REG_NONE, 40, 0, 0, 0);
    add_test("mem_rd_burst", K_MEM_RD, REG_NONE, 3, 3, 0, 0);
    add_test("mem_rd_40", K_MEM_RD, REG_NONE, 40, 1, 0, 0);
    add_test("sr_enable", K_APB_WR, REG_CTRL, 0, 32'h4, 0, 0);
    add_test("sr_status", K_APB_POLL, REG_STATUS, 0, 0, 32'h7, 0);
    add_test("sr_stall", K_NOT_READY, REG_NONE, 0, 20, 0, 0);
    add_test("sr_ctrl_rd", K_APB_RD, REG_CTRL, 0, 0, 32'h4, 0);
    add_test("sr_disable", K_APB_WR, REG_CTRL, 0, 32'h0, 0, 0);
    add_test("sr_exit", K_APB_POLL, REG_STATUS, 0, 0, 32'h3, 0);
    add_test("sr_data", K_MEM_RD, REG_NONE, 3, 3, 0, 0);
    add_test("zq_req_1", K_APB_WR, REG_CTRL, 0, 32'h2, 0, 0);
    add_test("zq_req_2", K_APB_WR, REG_CTRL, 0, 32'h2, 0, 0);
    add_test("zq_count", K_APB_POLL, REG_ZQCNT, 0, 0, 32'h2, 0);
    add_test("ref_base", K_APB_SNAP, REG_REFCNT, 0, 0, 0, 0);
    add_test("ref_req", K_APB_WR, REG_CTRL, 0, 32'h1, 0, 0);
    add_test("ref_count", K_APB_GT, REG_REFCNT, 0, 0, 0, 0);
    add_test("zq_exact", K_APB_RD, REG_ZQCNT, 0, 0, 32'h2, 0);
    add_test("temp_rd", K_APB_RD, REG_TEMP, 0, 0, TEMP_VAL, 0);
    add_test("unmapped_rd", K_APB_RD, REG_NONE, 0, 0, 0, 1);
    add_test("status_wr", K_APB_WR, REG_STATUS, 0, 32'hFF, 0, 1);
    add_test("ctrl_wr_all", K_APB_WR, REG_CTRL, 0, 32'hFFFF_FFFF, 0, 0);
    add_test("ctrl_rd_mask", K_APB_RD, REG_CTRL, 0, 0, 32'h4, 0);
    add_test("ctrl_clear", K_APB_WR, REG_CTRL, 0, 32'h0, 0, 0);
    add_test("sr_off", K_APB_POLL, REG_STATUS, 0, 0, 32'h3, 0);

    repeat (2) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < N_TESTS; i++) begin
      test_errs = 0;
      case (tbl[i].kind)
        K_CALIB: begin
          n = 0;
          do begin
            @(posedge clk);
            n++;
            @(negedge clk);
          end while (!calib_done);
          check_value(tbl[i].name, tbl[i].exp, n);
        end
        K_APB_WR: begin
          apb_access(1'b1, reg_addr(tbl[i].sel), tbl[i].data, rdata, err);
          check_value(tbl[i].name, tbl[i].exp_err, err);
        end
        K_APB_RD: begin
          apb_access(1'b0, reg_addr(tbl[i].sel), 0, rdata, err);
          check_value(tbl[i].name, tbl[i].exp, rdata);
          check_value(tbl[i].name, tbl[i].exp_err, err);
        end
        K_APB_POLL: begin
          do apb_access(1'b0, reg_addr(tbl[i].sel), 0, rdata, err);
          while (rdata !== tbl[i].exp);
          check_value(tbl[i].name, tbl[i].exp_err, err);
        end
        K_APB_SNAP: begin
          apb_access(1'b0, reg_addr(tbl[i].sel), 0, rdata, err);
          snap = rdata;
        end
        K_APB_GT: begin
          do apb_access(1'b0, reg_addr(tbl[i].sel), 0, rdata, err);
          while (rdata <= snap);
        end
        K_MEM_WR: mem_write(tbl[i].addr, $random(seed));
        K_MEM_RD: mem_read(tbl[i].name, tbl[i].addr, tbl[i].data);
        K_NOT_READY: begin
          repeat (tbl[i].data) begin
            @(negedge clk);
            check_value(tbl[i].name, 0, req_ready);
          end
        end
        default: test_errs++;
      endcase
      if (test_errs == 0) begin
        pass_cnt++;
        $display("%-14s ok", tbl[i].name);
      end else begin
        fail_cnt++;
        $display("%-14s FAILED with %0d errors", tbl[i].name, test_errs);
      end
    end

    $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+include
hdl/apb_regs_pkg.sv
hdl/ddr_ctrl_pkg.sv
hdl/apb_ddr.sv
hdl/ddr_calib_seq.sv
hdl/ddr_maint_sched.sv
hdl/ddr_mem_port.sv
hdl/ddr_subsys.sv
tests/ddr_subsys_chk.sv
tests/ddr_subsys_tb.sv
